// ==== Makefile ====
# Verilator build and run for the packet steering testbench

VERILATOR ?= verilator
TOP       ?= packet_steer_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= Simulation PASSED
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_STR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_STR)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/packet_steer_golden.txt ====
# I <word>                 input stream word, header or payload (hex)
# E <flow> <word> <last>   expected word on an output flow (hex)
# Header layout: destination in bits 11:8, length field in bits 7:0
# Packets cover every flow, one-word packets and dropped destinations
I 0002
I A001
I A002
I A003
E 0 A001 0
E 0 A002 0
E 0 A003 1
I 0100
I B001
E 1 B001 1
I 0401
I D001
I D002
I 0203
I C001
I C002
I C003
I C004
E 2 C001 0
E 2 C002 0
E 2 C003 0
E 2 C004 1
I 0300
I E001
E 3 E001 1
I 0F00
I D003
I 0301
I E002
I E003
E 3 E002 0
E 3 E003 1
I 0001
I A004
I A005
E 0 A004 0
E 0 A005 1
I 0101
I B002
I B003
E 1 B002 0
E 1 B003 1
I 0702
I D004
I D005
I D006
I 0100
I B004
E 1 B004 1

// ==== bench/packet_steer_tb.sv ====
`timescale 1ns/1ps
`include "steer_config.svh"

module packet_steer_tb;

  localparam int NF          = `STEER_NUM_FLOWS;
  localparam int DW          = `STEER_DATA_W;
  localparam int LW          = `STEER_LEN_W;
  localparam int DESTW       = `STEER_DEST_W;
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;
  localparam logic [31:0] SEED = 32'h9a3d6a36;

  logic                  clk;
  logic                  arst_n;
  logic                  in_valid;
  logic                  in_ready;
  logic [DW-1:0]         in_data;
  logic [NF-1:0]         out_valid;
  logic [NF-1:0]         out_ready;
  logic [NF-1:0][DW-1:0] out_data;
  logic [NF-1:0]         out_last;

  // Stream words in send order, headers included
  logic [DW-1:0] in_words[$];
  // Expected {last, word} per flow
  logic [DW:0]   exp_q[NF][$];

  logic [31:0]   gap_rng;
  logic          drive_ready;

  // Monitor state
  logic [NF-1:0]         held;
  logic [NF-1:0][DW-1:0] held_data;
  logic [NF-1:0]         held_last;
  logic                  in_header;
  int                    cur_dest;
  int                    beats_left;

  packet_steer_top i_packet_steer_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: actual 0x%0h expected 0x%0h", name, actual, expected));
    end
  endtask

  function automatic int count_pending();
    int total;
    total = 0;
    for (int f = 0; f < NF; f++) begin
      total += exp_q[f].size();
    end
    return total;
  endfunction

  // Lines tagged I are input words, lines tagged E expected flow words
  task automatic load_golden();
    int          fd;
    int          n;
    int          flow;
    string       line;
    logic [31:0] word;
    logic [31:0] last;
    fd = $fopen("bench/packet_steer_golden.txt", "r");
    if (fd == 0) begin
      fail_run("Cannot open the golden file bench/packet_steer_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) == "I") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h", word);
          if (n != 1) fail_run($sformatf("Bad input line in golden file: %s", line));
          else in_words.push_back(word[DW-1:0]);
        end else if (line.len() > 1 && line.getc(0) == "E") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", flow, word, last);
          if (n != 3 || flow < 0 || flow >= NF) begin
            fail_run($sformatf("Bad expected line in golden file: %s", line));
          end else begin
            exp_q[flow].push_back({last[0], word[DW-1:0]});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Random idle gap, then hold the word until in_ready takes it
  task automatic send_word(input logic [DW-1:0] word);
    int gap;
    int waited;
    gap_rng = next_random(gap_rng);
    gap = (gap_rng[1:0] == 2'b00) ? int'(gap_rng[3:2]) + 1 : 0;
    repeat (gap) begin
      @(negedge clk);
      in_valid = 1'b0;
      in_data  = DW'(gap_rng >> 8);
    end
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = word;
    waited   = 0;
    @(posedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) fail_run("Timeout waiting for in_ready on an input word");
      else @(posedge clk);
    end
  endtask

  // ----------------------------------------------------------------------
  // Random back-pressure per flow
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] ready_rng;
    out_ready = '0;
    ready_rng = next_random(SEED);
    forever begin
      @(negedge clk);
      if (drive_ready) begin
        ready_rng = next_random(ready_rng);
        // Each flow ready about three cycles in four
        for (int f = 0; f < NF; f++) begin
          out_ready[f] = (ready_rng[2*f +: 2] != 2'b00);
        end
      end else begin
        out_ready = '0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Output monitor and input-side packet model
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    logic [DW:0] exp_entry;
    if (!arst_n) begin
      held      = '0;
      in_header = 1'b1;
    end else begin
      for (int f = 0; f < NF; f++) begin
        // A stalled word stays put until it is taken
        if (held[f]) begin
          check_value($sformatf("out_valid[%0d]", f), 32'(out_valid[f]), 32'd1);
          check_value($sformatf("out_data[%0d]", f), 32'(out_data[f]), 32'(held_data[f]));
          check_value($sformatf("out_last[%0d]", f), 32'(out_last[f]), 32'(held_last[f]));
        end
        if (out_valid[f] && out_ready[f]) begin
          if (exp_q[f].size() == 0) begin
            fail_run($sformatf("Unexpected word 0x%0h on flow %0d", out_data[f], f));
          end else begin
            exp_entry = exp_q[f].pop_front();
            check_value($sformatf("out_data[%0d]", f), 32'(out_data[f]),
                        32'(exp_entry[DW-1:0]));
            check_value($sformatf("out_last[%0d]", f), 32'(out_last[f]),
                        32'(exp_entry[DW]));
          end
        end
        held[f]      = out_valid[f] && !out_ready[f];
        held_data[f] = out_data[f];
        held_last[f] = out_last[f];
      end
      if (in_valid && in_ready) begin
        if (in_header) begin
          cur_dest   = int'(in_data[LW +: DESTW]);
          beats_left = int'(in_data[LW-1:0]);
          in_header  = 1'b0;
        end else begin
          // No payload word may enter while its flow is full and stalled
          if (cur_dest < NF) begin
            check_value("flow_stalled_on_accept",
                        32'(out_valid[cur_dest] && !out_ready[cur_dest]), 32'd0);
          end
          if (beats_left == 0) in_header = 1'b1;
          else beats_left--;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int waited;
    int pending;
    arst_n      = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    drive_ready = 1'b0;
    gap_rng     = SEED;
    load_golden();
    if (in_words.size() == 0) fail_run("Golden file holds no input words");
    // Outputs idle and input open while in reset
    repeat (4) begin
      @(posedge clk);
      check_value("out_valid", 32'(out_valid), 32'd0);
      check_value("in_ready", 32'(in_ready), 32'd1);
    end
    @(negedge clk);
    arst_n = 1'b1;
    @(posedge clk);
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("in_ready", 32'(in_ready), 32'd1);
    drive_ready = 1'b1;
    foreach (in_words[i]) begin
      send_word(in_words[i]);
    end
    @(negedge clk);
    in_valid = 1'b0;
    // Let every flow drain
    waited  = 0;
    pending = count_pending();
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
      pending = count_pending();
    end
    if (pending != 0) begin
      fail_run($sformatf("Timeout waiting for the flows to drain, %0d words missing", pending));
    end else begin
      // Quiet period, a stray word would hit the monitor
      repeat (20) @(posedge clk);
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/steer_pkg.sv
verilog/flow_if.sv
verilog/packet_fsm.sv
verilog/beat_counter.sv
verilog/flow_reg_fwd.sv
verilog/flow_demux_select.sv
verilog/packet_steer_top.sv
bench/packet_steer_tb.sv

// ==== verilog/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
  input  logic            clk,
  input  logic            arst_n,
  // Load from the header length field
  input  logic            load,
  input  steer_pkg::len_t len,
  // One accepted payload or discard word
  input  logic            beat,
  // Current word is the final one of the packet
  output logic            at_last
);

  // Words left after the current one
  steer_pkg::len_t count_q;

  // ----------------------------------------------------------------------
  // Down-counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= len;
    end else if (beat) begin
      // Wraps after the last beat, reloaded by the next header anyway
      count_q <= count_q - steer_pkg::len_t'(1);
    end
  end

  // Zero remaining means this beat closes the packet
  assign at_last = (count_q == '0);

endmodule

// ==== verilog/flow_demux_select.sv ====
`timescale 1ns/1ps
`include "steer_config.svh"

module flow_demux_select (
  input  logic                                       clk,
  input  logic                                       arst_n,
  // Binary flow select, stable across a packet body
  input  steer_pkg::sel_t                            select,
  flow_if.dst                                        push,
  // Registered per-flow outputs
  output steer_pkg::flow_mask_t                      pop_valid,
  input  steer_pkg::flow_mask_t                      pop_ready,
  output steer_pkg::data_t [`STEER_NUM_FLOWS-1:0]    pop_data,
  output steer_pkg::flow_mask_t                      pop_last
);

  steer_pkg::flow_mask_t internal_valid;
  steer_pkg::flow_mask_t internal_ready;

  // ----------------------------------------------------------------------
  // Combinational steering
  // ----------------------------------------------------------------------

  // Valid reaches the selected register only
  always_comb begin
    for (int i = 0; i < `STEER_NUM_FLOWS; i++) begin
      internal_valid[i] = push.valid && (select == steer_pkg::sel_t'(i));
    end
  end

  // Ready comes back from that same register
  // Leaves a combinational path from pop_ready to push ready
  assign push.ready = internal_ready[select];

  // ----------------------------------------------------------------------
  // One forward register per flow
  // ----------------------------------------------------------------------
  // Hides the unstable demux outputs from the flow consumers
  for (genvar i = 0; i < `STEER_NUM_FLOWS; i++) begin : gen_pop_reg
    flow_reg_fwd i_flow_reg_fwd (
      .clk        (clk),
      .arst_n     (arst_n),
      .push_valid (internal_valid[i]),
      .push_ready (internal_ready[i]),
      .push_data  (push.data),
      .push_last  (push.last),
      .pop_valid  (pop_valid[i]),
      .pop_ready  (pop_ready[i]),
      .pop_data   (pop_data[i]),
      .pop_last   (pop_last[i])
    );
  end

endmodule

// ==== verilog/flow_if.sv ====
`timescale 1ns/1ps

// Ready/valid word channel with a last marker
// A word moves in any cycle where valid and ready are both 1
interface flow_if;

  logic              valid;
  logic              ready;
  steer_pkg::data_t  data;
  // Marks the final payload word of a packet
  logic              last;

  // Producer side
  modport src (
    output valid,
    output data,
    output last,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

// ==== verilog/flow_reg_fwd.sv ====
`timescale 1ns/1ps

module flow_reg_fwd (
  input  logic             clk,
  input  logic             arst_n,
  // Push side
  input  logic             push_valid,
  output logic             push_ready,
  input  steer_pkg::data_t push_data,
  input  logic             push_last,
  // Pop side
  output logic             pop_valid,
  input  logic             pop_ready,
  output steer_pkg::data_t pop_data,
  output logic             pop_last
);

  logic             valid_q;
  steer_pkg::data_t data_q;
  logic             last_q;

  // Room when empty or when the held word leaves this cycle
  assign push_ready = !valid_q || pop_ready;

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (push_ready) begin
      valid_q <= push_valid;
    end
  end

  // Payload, written on every accepted word
  always_ff @(posedge clk) begin
    if (push_valid && push_ready) begin
      data_q <= push_data;
      last_q <= push_last;
    end
  end

  assign pop_valid = valid_q;
  assign pop_data  = data_q;
  assign pop_last  = last_q;

endmodule

// ==== verilog/packet_fsm.sv ====
`timescale 1ns/1ps
`include "steer_config.svh"

module packet_fsm (
  input  logic                    clk,
  input  logic                    arst_n,
  // Input stream
  input  logic                    in_valid,
  output logic                    in_ready,
  input  steer_pkg::data_t        in_data,
  // Flow select toward the demux, held for the whole body
  output steer_pkg::sel_t         select,
  flow_if.src                     body,
  // Beat counter control
  output logic                    ctr_load,
  output steer_pkg::len_t         ctr_len,
  output logic                    ctr_beat,
  input  logic                    at_last
);

  steer_pkg::parse_state_t state_q;
  steer_pkg::parse_state_t state_d;
  steer_pkg::sel_t         sel_q;
  steer_pkg::dest_t        hdr_dest;
  logic                    hdr_valid_dest;

  // ----------------------------------------------------------------------
  // Header field decode
  // ----------------------------------------------------------------------
  assign hdr_dest       = in_data[`STEER_LEN_W +: `STEER_DEST_W];
  assign hdr_valid_dest = int'(hdr_dest) < `STEER_NUM_FLOWS;

  // Length goes straight to the counter, only sampled on load
  assign ctr_len = in_data[`STEER_LEN_W-1:0];

  // Payload path, data and last are don't-care outside the body
  assign body.data = in_data;
  assign body.last = at_last;
  assign select    = sel_q;

  // ----------------------------------------------------------------------
  // Next state and handshake
  // ----------------------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    in_ready   = 1'b1;
    body.valid = 1'b0;
    ctr_load   = 1'b0;
    ctr_beat   = 1'b0;
    unique case (state_q)
      steer_pkg::S_HEAD: begin
        // Header always taken, counter loads on the same edge
        ctr_load = in_valid;
        if (in_valid) begin
          state_d = hdr_valid_dest ? steer_pkg::S_BODY : steer_pkg::S_DROP;
        end
      end
      steer_pkg::S_BODY: begin
        // Stall follows the selected flow register
        body.valid = in_valid;
        in_ready   = body.ready;
        ctr_beat   = in_valid && body.ready;
        if (ctr_beat && at_last) begin
          state_d = steer_pkg::S_HEAD;
        end
      end
      steer_pkg::S_DROP: begin
        // Swallow every word of an unroutable packet
        ctr_beat = in_valid;
        if (in_valid && at_last) begin
          state_d = steer_pkg::S_HEAD;
        end
      end
      default: begin
        state_d = steer_pkg::S_HEAD;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= steer_pkg::S_HEAD;
      sel_q   <= '0;
    end else begin
      state_q <= state_d;
      // Capture the flow on a routable header only
      if (ctr_load && hdr_valid_dest) begin
        sel_q <= steer_pkg::sel_t'(hdr_dest);
      end
    end
  end

endmodule

// ==== verilog/packet_steer_top.sv ====
`timescale 1ns/1ps
`include "steer_config.svh"

module packet_steer_top (
  input  logic                                       clk,
  input  logic                                       arst_n,
  // Input packet stream, header word then payload words
  input  logic                                       in_valid,
  output logic                                       in_ready,
  input  steer_pkg::data_t                           in_data,
  // Per-flow payload streams
  output steer_pkg::flow_mask_t                      out_valid,
  input  steer_pkg::flow_mask_t                      out_ready,
  output steer_pkg::data_t [`STEER_NUM_FLOWS-1:0]    out_data,
  output steer_pkg::flow_mask_t                      out_last
);

  // ----------------------------------------------------------------------
  // Internal links
  // ----------------------------------------------------------------------

  // Payload words from the parser into the demux
  flow_if body_if ();

  steer_pkg::sel_t select;

  // Beat counter control and status
  logic            ctr_load;
  steer_pkg::len_t ctr_len;
  logic            ctr_beat;
  logic            at_last;

  // ----------------------------------------------------------------------
  // Header parser
  // ----------------------------------------------------------------------
  packet_fsm i_packet_fsm (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .select   (select),
    .body     (body_if.src),
    .ctr_load (ctr_load),
    .ctr_len  (ctr_len),
    .ctr_beat (ctr_beat),
    .at_last  (at_last)
  );

  // Tracks the remaining payload words of the current packet
  beat_counter i_beat_counter (
    .clk     (clk),
    .arst_n  (arst_n),
    .load    (ctr_load),
    .len     (ctr_len),
    .beat    (ctr_beat),
    .at_last (at_last)
  );

  // ----------------------------------------------------------------------
  // Flow demux with one output register per flow
  // ----------------------------------------------------------------------
  flow_demux_select i_flow_demux_select (
    .clk       (clk),
    .arst_n    (arst_n),
    .select    (select),
    .push      (body_if.dst),
    .pop_valid (out_valid),
    .pop_ready (out_ready),
    .pop_data  (out_data),
    .pop_last  (out_last)
  );

endmodule

// ==== verilog/steer_config.svh ====
`ifndef STEER_CONFIG_SVH
`define STEER_CONFIG_SVH

// ----------------------------------------------------------------------
// Stream geometry
// ----------------------------------------------------------------------

// Number of output flows behind the demux
`define STEER_NUM_FLOWS 4

// Width of one stream word, header and payload alike
`define STEER_DATA_W 16

// Header length field, low bits of the header word
`define STEER_LEN_W 8

// Header destination field, sits right above the length field
// Wider than the flow select so unused destinations can be encoded
`define STEER_DEST_W 4

`endif

// ==== verilog/steer_pkg.sv ====
`include "steer_config.svh"

package steer_pkg;

  // Select width, clamped to at least one bit for a single flow
  localparam int SEL_W = (`STEER_NUM_FLOWS > 1) ? $clog2(`STEER_NUM_FLOWS) : 1;

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------

  // One stream word
  typedef logic [`STEER_DATA_W-1:0] data_t;

  // Payload length, value n means n+1 payload words
  typedef logic [`STEER_LEN_W-1:0] len_t;

  // Raw destination field from the header
  typedef logic [`STEER_DEST_W-1:0] dest_t;

  // Flow select driven into the demux
  typedef logic [SEL_W-1:0] sel_t;

  // One bit per output flow
  typedef logic [`STEER_NUM_FLOWS-1:0] flow_mask_t;

  // ----------------------------------------------------------------------
  // Header parser states
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    S_HEAD,
    S_BODY,
    S_DROP
  } parse_state_t;

endpackage
